// ==== run.sh ====
#!/bin/sh
# Build and run the rvv_lite testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module rvv_lite_tb -f rvv_lite.f -o rvv_lite_sim

./obj_dir/rvv_lite_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0

// ==== rvv_exec.sv ====
`timescale 1ns/1ns
`include "rvv_lite_config.svh"

module rvv_exec (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       q_valid,
  input  rvv_lite_pkg::vinst_entry_t q_entry,
  output logic                       q_ready,
  output rvv_lite_pkg::reg_idx_t     rd_addr_a,
  input  rvv_lite_pkg::vreg_t        rd_data_a,
  output rvv_lite_pkg::reg_idx_t     rd_addr_b,
  input  rvv_lite_pkg::vreg_t        rd_data_b,
  output rvv_lite_pkg::reg_idx_t     rd_addr_c,
  input  rvv_lite_pkg::vreg_t        rd_data_c,
  output logic                       wr_en,
  output rvv_lite_pkg::reg_idx_t     wr_addr,
  output rvv_lite_pkg::elem_en_t     wr_elem_en,
  output rvv_lite_pkg::vreg_t        wr_data,
  output logic                       ex_valid,
  output rvv_lite_pkg::retire_t      ex_rec,
  input  logic                       ex_ready,
  output rvv_lite_pkg::vl_t          vl
);
  import rvv_lite_pkg::*;

  vinst_u   inst;
  elem_t    xval;
  logic     fire;
  logic     is_cfg;
  logic     is_vwr;
  logic     is_mvxs;
  logic     use_x;
  vl_t      vl_next;
  elem_en_t elem_en;
  vreg_t    alu_res;
  vreg_t    merged;

  assign inst     = q_entry.inst;
  assign xval     = q_entry.rs1_data;
  assign fire     = q_valid && ex_ready;
  assign ex_valid = q_valid;
  assign q_ready  = ex_ready;

  ////////////////////////////////////////
  // Decode.
  ////////////////////////////////////////

  always_comb begin
    is_cfg  = 1'b0;
    is_vwr  = 1'b0;
    is_mvxs = 1'b0;
    use_x   = 1'b0;
    if (inst.arith.opcode == OP_V) begin
      if (inst.cfg.funct3 == CFG) begin
        is_cfg = !inst.cfg.zero;
      end else if (inst.arith.vm) begin
        case (inst.arith.funct3)
          OPIVV: is_vwr = inst.arith.funct6 inside {F6_VADD, F6_VSUB, F6_VAND, F6_VOR, F6_VXOR};
          OPIVX: begin
            use_x  = 1'b1;
            is_vwr = (inst.arith.funct6 == F6_VADD) ||
                     (inst.arith.funct6 == F6_VMV && inst.arith.vs2 == '0);
          end
          OPMVV: is_mvxs = (inst.arith.funct6 == F6_VWXUNARY) && (inst.arith.vs1 == '0);
          // vmv.s.x and friends are not supported.
          OPMVX: is_vwr = 1'b0;
          default: is_vwr = 1'b0;
        endcase
      end
    end
  end

  assign vl_next = (xval > `RVV_ELEMS) ? vl_t'(`RVV_ELEMS) : vl_t'(xval);

  ////////////////////////////////////////
  // Element ALU.
  ////////////////////////////////////////

  always_comb begin
    elem_t opnd;
    for (int e = 0; e < `RVV_ELEMS; e++) begin
      opnd = use_x ? xval : rd_data_a[e];
      case (inst.arith.funct6)
        F6_VADD: alu_res[e] = rd_data_b[e] + opnd;
        F6_VSUB: alu_res[e] = rd_data_b[e] - opnd;
        F6_VAND: alu_res[e] = rd_data_b[e] & opnd;
        F6_VOR:  alu_res[e] = rd_data_b[e] | opnd;
        F6_VXOR: alu_res[e] = rd_data_b[e] ^ opnd;
        default: alu_res[e] = opnd;
      endcase
      elem_en[e] = (e < int'(vl));
      merged[e]  = elem_en[e] ? alu_res[e] : rd_data_c[e];
    end
  end

  assign rd_addr_a  = inst.arith.vs1;
  assign rd_addr_b  = inst.arith.vs2;
  assign rd_addr_c  = inst.arith.vd;
  assign wr_en      = fire && is_vwr;
  assign wr_addr    = inst.arith.vd;
  assign wr_elem_en = elem_en;
  assign wr_data    = alu_res;

  always_comb begin
    ex_rec         = '0;
    ex_rec.illegal = !(is_cfg || is_vwr || is_mvxs);
    if (is_vwr) begin
      ex_rec.vd_we   = 1'b1;
      ex_rec.vd      = inst.arith.vd;
      ex_rec.vd_data = merged;
    end
    if (is_cfg) begin
      ex_rec.xrf_we   = 1'b1;
      ex_rec.rd       = inst.cfg.rd;
      ex_rec.xrf_data = 32'(vl_next);
    end
    if (is_mvxs) begin
      ex_rec.xrf_we   = 1'b1;
      ex_rec.rd       = inst.arith.vd;
      ex_rec.xrf_data = rd_data_b[0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vl <= '0;
    end else if (fire && is_cfg) begin
      vl <= vl_next;
    end
  end

  // Stalled queue head must hold still.
  a_head_held: assert property (@(posedge clk) disable iff (!rst_n)
    (q_valid && !ex_ready) |=> (q_valid && $stable(q_entry)));

endmodule

// ==== rvv_inst_queue.sv ====
`timescale 1ns/1ns
`include "rvv_lite_config.svh"

module rvv_inst_queue (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       inst_valid,
  input  rvv_lite_pkg::vinst_entry_t inst,
  output logic                       inst_ready,
  output logic                       q_valid,
  output rvv_lite_pkg::vinst_entry_t q_entry,
  input  logic                       q_ready
);
  import rvv_lite_pkg::*;

  localparam int PTR_W = (`RVV_QDEPTH > 1) ? $clog2(`RVV_QDEPTH) : 1;
  localparam int CNT_W = $clog2(`RVV_QDEPTH + 1);

  vinst_entry_t     mem [`RVV_QDEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    ptr_inc = (p == PTR_W'(`RVV_QDEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign inst_ready = (count != CNT_W'(`RVV_QDEPTH));
  assign q_valid    = (count != '0);
  assign q_entry    = mem[rd_ptr];
  assign push       = inst_valid && inst_ready;
  assign pop        = q_valid && q_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= inst;
    end
  end

  // Full and not draining, so nothing may land.
  a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
    (!inst_ready && !pop) |=> ($stable(wr_ptr) && !inst_ready));

endmodule

// ==== rvv_lite.f ====
+incdir+.
rvv_lite_pkg.sv
rvv_inst_queue.sv
rvv_vrf.sv
rvv_exec.sv
rvv_retire.sv
rvv_lite.sv
rvv_lite_tb_clk.sv
rvv_lite_tb.sv

// ==== rvv_lite.sv ====
`timescale 1ns/1ns

module rvv_lite (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       inst_valid,
  input  rvv_lite_pkg::vinst_entry_t inst,
  output logic                       inst_ready,
  output logic                       rt_valid,
  output rvv_lite_pkg::retire_t      rt_rec,
  input  logic                       rt_ready,
  output rvv_lite_pkg::vl_t          vl
);
  import rvv_lite_pkg::*;

  logic         q_valid;
  vinst_entry_t q_entry;
  logic         q_ready;
  reg_idx_t     rd_addr_a;
  vreg_t        rd_data_a;
  reg_idx_t     rd_addr_b;
  vreg_t        rd_data_b;
  reg_idx_t     rd_addr_c;
  vreg_t        rd_data_c;
  logic         wr_en;
  reg_idx_t     wr_addr;
  elem_en_t     wr_elem_en;
  vreg_t        wr_data;
  logic         ex_valid;
  retire_t      ex_rec;
  logic         ex_ready;

  rvv_inst_queue i_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_ready (inst_ready),
    .q_valid    (q_valid),
    .q_entry    (q_entry),
    .q_ready    (q_ready)
  );

  rvv_exec i_exec (
    .clk        (clk),
    .rst_n      (rst_n),
    .q_valid    (q_valid),
    .q_entry    (q_entry),
    .q_ready    (q_ready),
    .rd_addr_a  (rd_addr_a),
    .rd_data_a  (rd_data_a),
    .rd_addr_b  (rd_addr_b),
    .rd_data_b  (rd_data_b),
    .rd_addr_c  (rd_addr_c),
    .rd_data_c  (rd_data_c),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_elem_en (wr_elem_en),
    .wr_data    (wr_data),
    .ex_valid   (ex_valid),
    .ex_rec     (ex_rec),
    .ex_ready   (ex_ready),
    .vl         (vl)
  );

  rvv_vrf i_vrf (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_addr_a  (rd_addr_a),
    .rd_data_a  (rd_data_a),
    .rd_addr_b  (rd_addr_b),
    .rd_data_b  (rd_data_b),
    .rd_addr_c  (rd_addr_c),
    .rd_data_c  (rd_data_c),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_elem_en (wr_elem_en),
    .wr_data    (wr_data)
  );

  rvv_retire i_retire (
    .clk      (clk),
    .rst_n    (rst_n),
    .ex_valid (ex_valid),
    .ex_rec   (ex_rec),
    .ex_ready (ex_ready),
    .rt_valid (rt_valid),
    .rt_rec   (rt_rec),
    .rt_ready (rt_ready)
  );

endmodule

// ==== rvv_lite_config.svh ====
`ifndef RVV_LITE_CONFIG_SVH
`define RVV_LITE_CONFIG_SVH

////////////////////////////////////////
// Vector unit geometry.
////////////////////////////////////////

// Vector register width in bits.
`define RVV_VLEN 128

// Elements per register, also VLMAX.
`define RVV_ELEMS 4

// Architectural vector registers.
`define RVV_NREGS 32

////////////////////////////////////////
// Buffering.
////////////////////////////////////////

`define RVV_QDEPTH 4

`endif

// ==== rvv_lite_pkg.sv ====
`include "rvv_lite_config.svh"

package rvv_lite_pkg;

  ////////////////////////////////////////
  // Basic types.
  ////////////////////////////////////////

  typedef logic [4:0] reg_idx_t;
  typedef logic [`RVV_VLEN/`RVV_ELEMS-1:0] elem_t;
  typedef elem_t [`RVV_ELEMS-1:0] vreg_t;
  typedef logic [`RVV_ELEMS-1:0] elem_en_t;
  typedef logic [$clog2(`RVV_ELEMS+1)-1:0] vl_t;

  ////////////////////////////////////////
  // Encodings.
  ////////////////////////////////////////

  localparam logic [6:0] OP_V  = 7'b1010111;

  // funct3 categories.
  localparam logic [2:0] OPIVV = 3'b000;
  localparam logic [2:0] OPMVV = 3'b010;
  localparam logic [2:0] OPIVX = 3'b100;
  localparam logic [2:0] OPMVX = 3'b110;
  localparam logic [2:0] CFG   = 3'b111;

  localparam logic [5:0] F6_VADD     = 6'b000000;
  localparam logic [5:0] F6_VSUB     = 6'b000010;
  localparam logic [5:0] F6_VAND     = 6'b001001;
  localparam logic [5:0] F6_VOR      = 6'b001010;
  localparam logic [5:0] F6_VXOR     = 6'b001011;
  localparam logic [5:0] F6_VWXUNARY = 6'b010000;
  localparam logic [5:0] F6_VMV      = 6'b010111;

  typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    reg_idx_t   vs2;
    reg_idx_t   vs1;
    logic [2:0] funct3;
    reg_idx_t   vd;
    logic [6:0] opcode;
  } varith_t;

  // vsetvli layout.
  typedef struct packed {
    logic        zero;
    logic [10:0] zimm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } vcfg_t;

  typedef union packed {
    varith_t arith;
    vcfg_t   cfg;
  } vinst_u;

  typedef struct packed {
    vinst_u      inst;
    logic [31:0] rs1_data;
  } vinst_entry_t;

  typedef struct packed {
    logic        illegal;
    logic        vd_we;
    reg_idx_t    vd;
    vreg_t       vd_data;
    logic        xrf_we;
    reg_idx_t    rd;
    logic [31:0] xrf_data;
  } retire_t;

endpackage

// ==== rvv_lite_tb.sv ====
`timescale 1ns/1ns
`include "rvv_lite_config.svh"

module rvv_lite_tb;
  import rvv_lite_pkg::*;

  localparam logic [31:0] SEED        = 32'h7b4d387b;
  localparam int          WAIT_LIMIT  = 500;
  localparam int          DRAIN_LIMIT = 2000;
  localparam int          VLMAX       = `RVV_ELEMS;
  localparam logic [6:0]  OPC_V       = 7'h57;
  localparam logic [2:0]  FN3_IVV     = 3'd0;
  localparam logic [2:0]  FN3_MVV     = 3'd2;
  localparam logic [2:0]  FN3_IVX     = 3'd4;
  localparam logic [2:0]  FN3_MVX     = 3'd6;
  localparam logic [2:0]  FN3_CFG     = 3'd7;
  localparam logic [5:0]  FN6_ADD     = 6'h00;
  localparam logic [5:0]  FN6_SUB     = 6'h02;
  localparam logic [5:0]  FN6_AND     = 6'h09;
  localparam logic [5:0]  FN6_OR      = 6'h0a;
  localparam logic [5:0]  FN6_XOR     = 6'h0b;
  localparam logic [5:0]  FN6_WXUN    = 6'h10;
  localparam logic [5:0]  FN6_MV      = 6'h17;

  logic         clk;
  logic         rst_n;
  logic         inst_valid;
  vinst_entry_t inst;
  logic         inst_ready;
  logic         rt_valid;
  retire_t      rt_rec;
  logic         rt_ready;
  vl_t          vl;

  logic [31:0] rng      = SEED;
  logic [31:0] bp_state = SEED;
  logic        bp_on    = 1'b0;
  logic        saw_full = 1'b0;
  logic [31:0] m_regs [32][4];
  int          m_vl;
  retire_t     exp_recs [1024];
  int          exp_vls [1024];
  int          exp_wr        = 0;
  int          chk_idx       = 0;
  int          checked       = 0;
  int          error_count   = 0;
  int          timeouts      = 0;
  int          tests_run     = 0;
  int          err_start;
  retire_t     exp_head;
  int          exp_vl_head;
  logic [5:0]  vv_ops [5] = '{FN6_ADD, FN6_SUB, FN6_AND, FN6_OR, FN6_XOR};

  rvv_lite_tb_clk i_clk (.clk(clk), .rst_n(rst_n));

  rvv_lite i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_ready (inst_ready),
    .rt_valid   (rt_valid),
    .rt_rec     (rt_rec),
    .rt_ready   (rt_ready),
    .vl         (vl)
  );

  ////////////////////////////////////////
  // Retire checking.
  ////////////////////////////////////////

  assign exp_head    = exp_recs[chk_idx];
  assign exp_vl_head = exp_vls[chk_idx];

  always @(posedge clk) begin
    if (rst_n && rt_valid && rt_ready) begin
      chk_idx <= chk_idx + 1;
      checked <= checked + 1;
    end
    if (bp_on && !inst_ready) begin
      saw_full <= 1'b1;
    end
  end

  a_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
    (rt_valid && rt_ready) |->
    ({rt_rec.illegal, rt_rec.vd_we, rt_rec.vd, rt_rec.xrf_we, rt_rec.rd} ==
     {exp_head.illegal, exp_head.vd_we, exp_head.vd, exp_head.xrf_we, exp_head.rd}))
    else begin
      $display("** Error: rt_rec {illegal,vd_we,vd,xrf_we,rd} = %h, expected %h",
               $sampled({rt_rec.illegal, rt_rec.vd_we, rt_rec.vd, rt_rec.xrf_we, rt_rec.rd}),
               $sampled({exp_head.illegal, exp_head.vd_we, exp_head.vd, exp_head.xrf_we,
                         exp_head.rd}));
      error_count++;
    end

  a_vd_data: assert property (@(posedge clk) disable iff (!rst_n)
    (rt_valid && rt_ready) |-> (rt_rec.vd_data == exp_head.vd_data))
    else begin
      $display("** Error: rt_rec.vd_data = %h, expected %h",
               $sampled(rt_rec.vd_data), $sampled(exp_head.vd_data));
      error_count++;
    end

  a_xrf_data: assert property (@(posedge clk) disable iff (!rst_n)
    (rt_valid && rt_ready) |-> (rt_rec.xrf_data == exp_head.xrf_data))
    else begin
      $display("** Error: rt_rec.xrf_data = %h, expected %h",
               $sampled(rt_rec.xrf_data), $sampled(exp_head.xrf_data));
      error_count++;
    end

  // vl already reflects the record being handed over.
  a_vl: assert property (@(posedge clk) disable iff (!rst_n)
    (rt_valid && rt_ready) |-> (int'(vl) == exp_vl_head))
    else begin
      $display("** Error: vl = %h, expected %h", $sampled(vl), $sampled(exp_vl_head));
      error_count++;
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (rt_valid && !rt_ready) |=> (rt_valid && $stable(rt_rec)))
    else begin
      $display("Retire record changed or dropped while the core stalled it");
      error_count++;
    end

  ////////////////////////////////////////
  // Stimulus helpers.
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic vinst_entry_t make_arith(input logic [5:0] f6, input logic vm,
      input logic [4:0] vs2, input logic [4:0] vs1, input logic [2:0] f3,
      input logic [4:0] vd, input logic [31:0] x);
    vinst_entry_t e;
    e.inst     = {f6, vm, vs2, vs1, f3, vd, OPC_V};
    e.rs1_data = x;
    return e;
  endfunction

  function automatic logic [31:0] alu_ref(input logic [5:0] f6, input logic [31:0] a,
      input logic [31:0] b);
    case (f6)
      FN6_ADD: return a + b;
      FN6_SUB: return a - b;
      FN6_AND: return a & b;
      FN6_OR:  return a | b;
      FN6_XOR: return a ^ b;
      default: return b;
    endcase
  endfunction

  task automatic send(input vinst_entry_t e, input retire_t r);
    int waited;
    waited = 0;
    exp_recs[exp_wr] = r;
    exp_vls[exp_wr]  = m_vl;
    exp_wr++;
    inst       = e;
    inst_valid = 1'b1;
    while (!inst_ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!inst_ready) begin
      $display("Timeout: inst_ready stayed low for %0d cycles", WAIT_LIMIT);
      timeouts++;
    end
    @(negedge clk);
    inst_valid = 1'b0;
  endtask

  task automatic config_vl(input logic [4:0] rd, input logic [31:0] avl);
    retire_t r;
    m_vl       = (avl > VLMAX) ? VLMAX : int'(avl);
    r          = '0;
    r.xrf_we   = 1'b1;
    r.rd       = rd;
    r.xrf_data = 32'(m_vl);
    send(make_arith({1'b0, 5'h00}, 1'b0, 5'h10, 5'(next_rand()), FN3_CFG, rd, avl), r);
  endtask

  // Covers the .vv forms, vadd.vx and vmv.v.x.
  task automatic write_vreg(input logic [5:0] f6, input logic [2:0] f3, input logic [4:0] vd,
      input logic [4:0] vs2, input logic [4:0] vs1, input logic [31:0] x);
    retire_t     r;
    logic [31:0] res [4];
    for (int e = 0; e < VLMAX; e++) begin
      res[e] = alu_ref(f6, m_regs[vs2][e], (f3 == FN3_IVX) ? x : m_regs[vs1][e]);
    end
    r       = '0;
    r.vd_we = 1'b1;
    r.vd    = vd;
    for (int e = 0; e < VLMAX; e++) begin
      if (e < m_vl) begin
        m_regs[vd][e] = res[e];
      end
      r.vd_data[e] = m_regs[vd][e];
    end
    send(make_arith(f6, 1'b1, vs2, vs1, f3, vd, x), r);
  endtask

  task automatic extract_elem0(input logic [4:0] rd, input logic [4:0] vs2);
    retire_t r;
    r          = '0;
    r.xrf_we   = 1'b1;
    r.rd       = rd;
    r.xrf_data = m_regs[vs2][0];
    send(make_arith(FN6_WXUN, 1'b1, vs2, 5'd0, FN3_MVV, rd, next_rand()), r);
  endtask

  task automatic expect_illegal(input vinst_entry_t e);
    retire_t r;
    r         = '0;
    r.illegal = 1'b1;
    send(e, r);
  endtask

  // Distinct elements by shrinking vl between broadcasts.
  task automatic load_reg(input logic [4:0] vd);
    for (int k = VLMAX; k >= 1; k--) begin
      config_vl(5'd0, 32'(k));
      write_vreg(FN6_MV, FN3_IVX, vd, 5'd0, 5'(next_rand()), next_rand());
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (chk_idx != exp_wr && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (chk_idx != exp_wr) begin
      $display("Timeout: %0d retire records never arrived", exp_wr - chk_idx);
      timeouts++;
    end
  endtask

  // Changed on a rising edge, away from the falling-edge drivers.
  task automatic set_backpressure(input logic on);
    @(posedge clk);
    bp_on = on;
    @(negedge clk);
  endtask

  task automatic start_test();
    err_start = error_count + timeouts;
  endtask

  task automatic end_test(input string name);
    wait_drain();
    tests_run++;
    $display("%-28s done, %0d errors", name, error_count + timeouts - err_start);
  endtask

  initial begin
    rt_ready = 1'b1;
    forever begin
      @(negedge clk);
      if (bp_on) begin
        bp_state = xorshift(bp_state);
        rt_ready = (bp_state[1:0] == 2'b00);
      end else begin
        rt_ready = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Test sequence.
  ////////////////////////////////////////

  initial begin
    int          waited;
    int          kind;
    logic [4:0]  tgt;
    logic [31:0] avls [4];
    inst_valid = 1'b0;
    inst       = '0;
    m_vl       = 0;
    avls       = '{32'd0, 32'd3, 32'd4, 32'd9};
    for (int r = 0; r < 32; r++) begin
      for (int e = 0; e < 4; e++) begin
        m_regs[r][e] = '0;
      end
    end
    waited = 0;
    while (rst_n !== 1'b1 && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset was never released");
      timeouts++;
    end
    @(negedge clk);
    assert (!rt_valid && inst_ready && vl == '0) else begin
      $display("Outputs not in their reset state after reset");
      error_count++;
    end

    start_test();
    foreach (avls[i]) begin
      config_vl(5'(next_rand()), avls[i]);
    end
    end_test("vsetvli and vl");

    start_test();
    for (int r = 0; r < 8; r++) begin
      load_reg(5'(r));
    end
    for (int i = 0; i < 20; i++) begin
      if (i % 4 == 0) begin
        config_vl(5'(next_rand()), next_rand() % 6);
      end
      write_vreg(vv_ops[next_rand() % 5], FN3_IVV, 5'(next_rand() % 8),
                 5'(next_rand() % 8), 5'(next_rand() % 8), next_rand());
    end
    end_test("vv ALU operations");

    start_test();
    for (int i = 0; i < 12; i++) begin
      config_vl(5'(next_rand()), next_rand() % 6);
      if (i % 2 == 1) begin
        write_vreg(FN6_ADD, FN3_IVX, 5'(next_rand() % 8), 5'(next_rand() % 8),
                   5'(next_rand()), next_rand());
      end else begin
        write_vreg(FN6_MV, FN3_IVX, 5'(next_rand() % 8), 5'd0, 5'(next_rand()), next_rand());
      end
    end
    end_test("vx broadcast");

    start_test();
    for (int i = 0; i < 6; i++) begin
      extract_elem0(5'(next_rand()), 5'(next_rand() % 8));
    end
    end_test("vmv.x.s");

    start_test();
    tgt = 5'd3;
    config_vl(5'd1, 32'd4);
    expect_illegal(make_arith(FN6_ADD, 1'b0, 5'd1, 5'd2, FN3_IVV, tgt, 32'h0));
    expect_illegal(make_arith(FN6_ADD, 1'b1, 5'd1, 5'd2, FN3_MVX, tgt, 32'h55));
    expect_illegal(make_arith(6'h25, 1'b1, 5'd1, 5'd2, FN3_IVV, tgt, 32'h0));
    expect_illegal(make_arith(FN6_MV, 1'b1, 5'd5, 5'd0, FN3_IVX, tgt, 32'hdead));
    expect_illegal(make_arith(FN6_WXUN, 1'b1, tgt, 5'd3, FN3_MVV, 5'd4, 32'h0));
    expect_illegal(make_arith({1'b1, 5'h00}, 1'b0, 5'd0, 5'd2, FN3_CFG, tgt, 32'd1));
    expect_illegal('{inst: {FN6_ADD, 1'b1, 5'd1, 5'd2, FN3_IVV, tgt, 7'h33}, rs1_data: 32'h0});
    extract_elem0(5'd7, tgt);
    write_vreg(FN6_OR, FN3_IVV, tgt, tgt, tgt, 32'h0);
    end_test("illegal encodings");

    start_test();
    set_backpressure(1'b1);
    for (int i = 0; i < 60; i++) begin
      kind = next_rand() % 7;
      case (kind)
        0: config_vl(5'(next_rand()), next_rand() % 6);
        1, 2: write_vreg(vv_ops[next_rand() % 5], FN3_IVV, 5'(next_rand() % 8),
                         5'(next_rand() % 8), 5'(next_rand() % 8), next_rand());
        3: write_vreg(FN6_ADD, FN3_IVX, 5'(next_rand() % 8), 5'(next_rand() % 8),
                      5'(next_rand()), next_rand());
        4: write_vreg(FN6_MV, FN3_IVX, 5'(next_rand() % 8), 5'd0, 5'(next_rand()), next_rand());
        5: extract_elem0(5'(next_rand()), 5'(next_rand() % 8));
        default: expect_illegal(make_arith(FN6_XOR, 1'b0, 5'd1, 5'd2, FN3_IVV, 5'd6, 32'h0));
      endcase
    end
    wait_drain();
    set_backpressure(1'b0);
    assert (saw_full) else begin
      $display("inst_ready never dropped although the queue should have filled");
      error_count++;
    end
    end_test("back-pressure ordering");

    $display("Tests %0d, records checked %0d, errors %0d, timeouts %0d",
             tests_run, checked, error_count, timeouts);
    if (error_count == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== rvv_lite_tb_clk.sv ====
`timescale 1ns/1ns

module rvv_lite_tb_clk (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 50;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Two rising edges in reset, released on a falling edge.
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== rvv_retire.sv ====
`timescale 1ns/1ns

module rvv_retire (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ex_valid,
  input  rvv_lite_pkg::retire_t ex_rec,
  output logic                  ex_ready,
  output logic                  rt_valid,
  output rvv_lite_pkg::retire_t rt_rec,
  input  logic                  rt_ready
);

  // Take a new record when empty or being drained.
  assign ex_ready = !rt_valid || rt_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rt_valid <= 1'b0;
    end else if (ex_ready) begin
      rt_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid && ex_ready) begin
      rt_rec <= ex_rec;
    end
  end

  ////////////////////////////////////////
  // Checks.
  ////////////////////////////////////////

  a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    (rt_valid && !rt_ready) |=> (rt_valid && $stable(rt_rec)));

  // Illegal records never carry a write.
  a_illegal_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    (rt_valid && rt_rec.illegal) |-> (!rt_rec.vd_we && !rt_rec.xrf_we));

endmodule

// ==== rvv_vrf.sv ====
`timescale 1ns/1ns
`include "rvv_lite_config.svh"

module rvv_vrf (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rvv_lite_pkg::reg_idx_t rd_addr_a,
  output rvv_lite_pkg::vreg_t    rd_data_a,
  input  rvv_lite_pkg::reg_idx_t rd_addr_b,
  output rvv_lite_pkg::vreg_t    rd_data_b,
  input  rvv_lite_pkg::reg_idx_t rd_addr_c,
  output rvv_lite_pkg::vreg_t    rd_data_c,
  input  logic                   wr_en,
  input  rvv_lite_pkg::reg_idx_t wr_addr,
  input  rvv_lite_pkg::elem_en_t wr_elem_en,
  input  rvv_lite_pkg::vreg_t    wr_data
);
  import rvv_lite_pkg::*;

  vreg_t regs [`RVV_NREGS];

  // Port c returns the old destination for merging.
  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];
  assign rd_data_c = regs[rd_addr_c];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < `RVV_NREGS; r++) begin
        regs[r] <= '0;
      end
    end else if (wr_en) begin
      for (int e = 0; e < `RVV_ELEMS; e++) begin
        if (wr_elem_en[e]) begin
          regs[wr_addr][e] <= wr_data[e];
        end
      end
    end
  end

endmodule
